/* common/cpu_settings.svh */
// Memory depth, register count and hold counter width macros
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Memory
////////////////////////////////////////////////////////////

// Unified program and data memory, one word per address
`define CPU_MEM_DEPTH 256

////////////////////////////////////////////////////////////
// Core
////////////////////////////////////////////////////////////

`define CPU_NUM_REGS 8  // r0 reads as zero

// Decode hold counter width, saturates at all ones
`define CPU_HOLD_BITS 4

`endif

/* common/cpu_pkg.sv */
// Shared word, address, register, sequence and hold types plus opcode and owner enums
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [15:0] word_t;      // Data and instruction word
    typedef logic [7:0]  mem_addr_t;  // Memory address, matches CPU_MEM_DEPTH
    typedef logic [2:0]  reg_idx_t;   // Register index
    typedef logic [15:0] seq_id_t;    // Instruction sequence id

    // Decode hold cycles per instruction
    typedef logic [`CPU_HOLD_BITS-1:0] hold_cnt_t;

    // Instruction bits 15..12
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,  // rd = rd + rs
        OP_SUB  = 4'h1,  // rd = rd - rs
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h4,  // rd = rd + sext(imm)
        OP_LD   = 4'h5,  // rd = mem[rs + sext(imm)]
        OP_ST   = 4'h6,  // mem[rs + sext(imm)] = rd
        OP_NOP  = 4'h7,
        OP_HALT = 4'h8   // Stops fetch
    } opcode_e;

    // Owner of the single memory port in a given cycle
    typedef enum logic {
        FETCH_OWNER = 1'b0,
        DATA_OWNER  = 1'b1
    } mem_owner_e;

endpackage

`default_nettype wire

/* pipeline/register_file.sv */
// Eight-entry register file with r0 at zero, two read ports and a write-first write port
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rs_a,
    input  cpu_pkg::reg_idx_t rs_b,
    input  logic              we,
    input  cpu_pkg::reg_idx_t wd_idx,
    input  cpu_pkg::word_t    wd,
    output cpu_pkg::word_t    rd_a,
    output cpu_pkg::word_t    rd_b
);
    import cpu_pkg::*;

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wd_idx != '0)) begin
            regs[wd_idx] <= wd;
        end
    end

    // Same-cycle write is bypassed to the readers
    assign rd_a = (rs_a == '0) ? '0 : (we && (wd_idx == rs_a)) ? wd : regs[rs_a];
    assign rd_b = (rs_b == '0) ? '0 : (we && (wd_idx == rs_b)) ? wd : regs[rs_b];

endmodule

`default_nettype wire

/* pipeline/pipeline_core.sv */
// Five-stage core with pc, stage registers, decode, ALU, interlock, HALT stop and retire outputs
`timescale 1ns/1ps
`default_nettype none

module pipeline_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,           // Level, fetch starts one cycle after it rises
    input  logic               fetch_grant,   // Combinational grant from the arbiter
    input  cpu_pkg::word_t     rdata,         // Fetch or load data, one cycle after the grant
    output logic               fetch_req,
    output cpu_pkg::mem_addr_t fetch_addr,
    output logic               data_req,
    output logic               data_we,
    output cpu_pkg::mem_addr_t data_addr,
    output cpu_pkg::word_t     data_wdata,
    output logic               fetch_fire,
    output logic               decode_hold,
    output logic               retire_valid,
    output cpu_pkg::mem_addr_t retire_pc,
    output logic               retire_we,
    output cpu_pkg::reg_idx_t  retire_rd,
    output cpu_pkg::word_t     retire_value,
    output logic               halted
);
    import cpu_pkg::*;

    // Opcode classes used by the interlock and write-back
    function automatic logic writes_reg(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD};
    endfunction

    function automatic logic reads_rs(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LD, OP_ST};
    endfunction

    function automatic logic reads_rd(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_ST};
    endfunction

    logic      run_q;
    logic      halt_seen;      // HALT has left decode
    mem_addr_t pc;

    // Fetch/decode register
    logic      dec_valid;
    logic      dec_from_mem;   // Instruction is on rdata this cycle
    word_t     dec_instr_q;    // Copy kept while decode holds
    mem_addr_t dec_pc;
    word_t     dec_instr;
    opcode_e   dec_op;
    reg_idx_t  dec_rd;
    reg_idx_t  dec_rs;
    word_t     dec_imm;
    word_t     dec_a;          // Register rd value
    word_t     dec_b;          // Register rs value
    logic      dec_halt;
    logic      rs_hit;
    logic      rd_hit;

    // Decode/execute register
    logic      ex_valid;
    opcode_e   ex_op;
    reg_idx_t  ex_rd;
    mem_addr_t ex_pc;
    word_t     ex_a;
    word_t     ex_b;
    word_t     ex_imm;
    word_t     ex_result;
    logic      ex_wr;

    // Execute/memory register
    logic      mem_valid;
    opcode_e   mem_op;
    reg_idx_t  mem_rd;
    mem_addr_t mem_pc;
    logic      mem_we_q;
    word_t     mem_result;     // ALU result or LD/ST address
    word_t     mem_sdata;      // Store data
    logic      mem_wr;

    // Memory/write-back register
    logic      wb_valid;
    opcode_e   wb_op;
    reg_idx_t  wb_rd;
    mem_addr_t wb_pc;
    logic      wb_we;
    word_t     wb_result;
    word_t     wb_value;
    logic      wb_write;

    ////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////

    assign dec_instr = dec_from_mem ? rdata : dec_instr_q;
    assign dec_op    = opcode_e'(dec_instr[15:12]);
    assign dec_rd    = dec_instr[11:9];
    assign dec_rs    = dec_instr[8:6];
    assign dec_imm   = {{10{dec_instr[5]}}, dec_instr[5:0]};  // Sign extended
    assign dec_halt  = dec_valid && (dec_op == OP_HALT);

    // Interlock against writers in execute and memory, r0 never conflicts
    assign ex_wr  = ex_valid && writes_reg(ex_op) && (ex_rd != '0);
    assign mem_wr = mem_valid && mem_we_q && (mem_rd != '0);
    assign rs_hit = reads_rs(dec_op) &&
                    ((ex_wr && (ex_rd == dec_rs)) || (mem_wr && (mem_rd == dec_rs)));
    assign rd_hit = reads_rd(dec_op) &&
                    ((ex_wr && (ex_rd == dec_rd)) || (mem_wr && (mem_rd == dec_rd)));
    assign decode_hold = dec_valid && (rs_hit || rd_hit);

    // No fetch while decode is blocked or once HALT is seen
    assign fetch_req  = run_q && !halt_seen && !dec_halt && !decode_hold;
    assign fetch_addr = pc;
    assign fetch_fire = fetch_req && fetch_grant;

    register_file u_register_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs_a   (dec_rd),
        .rs_b   (dec_rs),
        .we     (wb_write),
        .wd_idx (wb_rd),
        .wd     (wb_value),
        .rd_a   (dec_a),
        .rd_b   (dec_b)
    );

    ////////////////////////////////////////////////////////////
    // Execute and memory
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ex_op)
            OP_ADD:       ex_result = ex_a + ex_b;
            OP_SUB:       ex_result = ex_a - ex_b;
            OP_AND:       ex_result = ex_a & ex_b;
            OP_XOR:       ex_result = ex_a ^ ex_b;
            OP_ADDI:      ex_result = ex_a + ex_imm;
            OP_LD, OP_ST: ex_result = ex_b + ex_imm;  // Effective address
            default:      ex_result = '0;
        endcase
    end

    assign data_req   = mem_valid && ((mem_op == OP_LD) || (mem_op == OP_ST));
    assign data_we    = mem_valid && (mem_op == OP_ST);
    assign data_addr  = mem_result[7:0];  // Truncated to the memory range
    assign data_wdata = mem_sdata;

    // Load data arrives one cycle later, in write-back
    assign wb_value = (wb_op == OP_LD) ? rdata : wb_result;
    assign wb_write = wb_valid && wb_we;

    assign retire_valid = wb_valid;
    assign retire_pc    = wb_pc;
    assign retire_we    = wb_write;
    assign retire_rd    = wb_rd;
    assign retire_value = wb_value;

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q        <= 1'b0;
            halt_seen    <= 1'b0;
            pc           <= '0;
            dec_valid    <= 1'b0;
            dec_from_mem <= 1'b0;
            ex_valid     <= 1'b0;
            mem_valid    <= 1'b0;
            wb_valid     <= 1'b0;
            halted       <= 1'b0;
        end else begin
            run_q <= run;
            if (fetch_fire) begin
                pc <= pc + 1'b1;
            end
            if (dec_halt) begin
                halt_seen <= 1'b1;                  // HALT never holds in decode
            end
            dec_valid    <= decode_hold || fetch_fire;
            dec_from_mem <= fetch_fire;
            ex_valid     <= dec_valid && !decode_hold;  // Bubble on hold
            mem_valid    <= ex_valid;
            wb_valid     <= mem_valid;
            if (wb_valid && (wb_op == OP_HALT)) begin
                halted <= 1'b1;
            end
        end
    end

    // Stage payload, qualified by the valid bits
    always_ff @(posedge clk) begin
        dec_instr_q <= dec_instr;
        if (fetch_fire) begin
            dec_pc <= pc;
        end
        ex_op      <= dec_op;
        ex_rd      <= dec_rd;
        ex_pc      <= dec_pc;
        ex_a       <= dec_a;
        ex_b       <= dec_b;
        ex_imm     <= dec_imm;
        mem_op     <= ex_op;
        mem_rd     <= ex_rd;
        mem_pc     <= ex_pc;
        mem_we_q   <= writes_reg(ex_op);
        mem_result <= ex_result;
        mem_sdata  <= ex_a;
        wb_op      <= mem_op;
        wb_rd      <= mem_rd;
        wb_pc      <= mem_pc;
        wb_we      <= mem_we_q;
        wb_result  <= mem_result;
    end

endmodule

`default_nettype wire

/* hdl/memory_arbiter.sv */
// Fixed-priority arbiter between fetch and the memory stage with read data routing
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_req,
    input  cpu_pkg::mem_addr_t fetch_addr,
    input  logic               data_req,
    input  logic               data_we,
    input  cpu_pkg::mem_addr_t data_addr,
    input  cpu_pkg::word_t     data_wdata,
    output logic               fetch_grant,
    output cpu_pkg::word_t     rdata,
    output logic               mem_en,
    output logic               mem_we,
    output cpu_pkg::mem_addr_t mem_addr,
    output cpu_pkg::word_t     mem_wdata,
    input  cpu_pkg::word_t     mem_rdata
);
    import cpu_pkg::*;

    // A fetch slot with no read behind it decodes as NOP
    localparam word_t NOP_WORD = {OP_NOP, 12'h000};

    mem_owner_e owner;        // Owner this cycle
    mem_owner_e owner_q;      // Owner of the access that returns now
    logic       ret_valid_q;  // Last access was a read

    assign owner       = data_req ? DATA_OWNER : FETCH_OWNER;  // Memory stage always wins
    assign fetch_grant = fetch_req && !data_req;
    assign mem_en      = data_req || fetch_req;
    assign mem_we      = data_req && data_we;
    assign mem_addr    = (owner == DATA_OWNER) ? data_addr : fetch_addr;
    assign mem_wdata   = data_wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q     <= FETCH_OWNER;
            ret_valid_q <= 1'b0;
        end else begin
            owner_q     <= owner;
            ret_valid_q <= mem_en && !mem_we;
        end
    end

    always_comb begin
        if (ret_valid_q) begin
            rdata = mem_rdata;                  // Fetch word or load data
        end else if (owner_q == FETCH_OWNER) begin
            rdata = NOP_WORD;
        end else begin
            rdata = '0;                         // Store cycle
        end
    end

endmodule

`default_nettype wire

/* hdl/unified_memory.sv */
// Single-port program and data memory with registered read and external load port
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module unified_memory (
    input  logic               clk,
    input  logic               mem_en,
    input  logic               mem_we,
    input  cpu_pkg::mem_addr_t mem_addr,
    input  cpu_pkg::word_t     mem_wdata,
    input  logic               load_en,    // Already gated with run low
    input  cpu_pkg::mem_addr_t load_addr,
    input  cpu_pkg::word_t     load_data,
    output cpu_pkg::word_t     mem_rdata
);
    import cpu_pkg::*;

    word_t     mem [`CPU_MEM_DEPTH];
    logic      wr_en;
    mem_addr_t wr_addr;
    word_t     wr_data;

    // One write port, the load path takes it when active
    assign wr_en   = load_en || (mem_en && mem_we);
    assign wr_addr = load_en ? load_addr : mem_addr;
    assign wr_data = load_en ? load_data : mem_wdata;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (mem_en && !mem_we) begin
            mem_rdata <= mem[mem_addr];  // One cycle read latency
        end
    end

endmodule

`default_nettype wire

/* hdl/retire_tracker.sv */
// Sequence ids and decode hold counts carried in a shadow pipeline up to retire
`timescale 1ns/1ps
`default_nettype none

module retire_tracker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_fire,
    input  logic               decode_hold,
    input  logic               retire_valid,
    output cpu_pkg::seq_id_t   retire_id,
    output cpu_pkg::hold_cnt_t retire_holds
);
    import cpu_pkg::*;

    localparam hold_cnt_t HOLD_MAX = '1;  // Saturation point

    seq_id_t   next_id;    // Id of the next fetched instruction
    seq_id_t   dec_id;
    seq_id_t   ex_id;
    seq_id_t   mem_id;
    seq_id_t   wb_id;
    hold_cnt_t dec_holds;
    hold_cnt_t ex_holds;
    hold_cnt_t mem_holds;
    hold_cnt_t wb_holds;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_id <= '0;
        end else if (fetch_fire) begin
            next_id <= next_id + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Shadow stages, same stall rule as the core
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (decode_hold) begin
            // Decode entry stays and counts, execute gets a bubble
            if (dec_holds != HOLD_MAX) begin
                dec_holds <= dec_holds + 1'b1;
            end
            ex_id    <= '0;
            ex_holds <= '0;
        end else begin
            dec_id    <= next_id;   // Entry from this cycle's fetch
            dec_holds <= '0;
            ex_id     <= dec_id;
            ex_holds  <= dec_holds;
        end
        mem_id    <= ex_id;
        mem_holds <= ex_holds;
        wb_id     <= mem_id;
        wb_holds  <= mem_holds;
    end

    // Zero between retirements
    assign retire_id    = retire_valid ? wb_id : '0;
    assign retire_holds = retire_valid ? wb_holds : '0;

endmodule

`default_nettype wire

/* hdl/cpu_top.sv */
// Top level joining the core, retire tracker, memory arbiter and unified memory
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               load_en,
    input  cpu_pkg::mem_addr_t load_addr,
    input  cpu_pkg::word_t     load_data,
    output logic               retire_valid,
    output cpu_pkg::seq_id_t   retire_id,
    output cpu_pkg::hold_cnt_t retire_holds,
    output cpu_pkg::mem_addr_t retire_pc,
    output logic               retire_we,
    output cpu_pkg::reg_idx_t  retire_rd,
    output cpu_pkg::word_t     retire_value,
    output logic               halted
);
    import cpu_pkg::*;

    // Core to arbiter
    logic      fetch_req;
    mem_addr_t fetch_addr;
    logic      fetch_grant;
    logic      data_req;
    logic      data_we;
    mem_addr_t data_addr;
    word_t     data_wdata;
    word_t     rdata;

    // Arbiter to memory
    logic      mem_en;
    logic      mem_we;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;

    // Core to tracker
    logic      fetch_fire;
    logic      decode_hold;

    logic      load_en_idle;

    assign load_en_idle = load_en && !run;  // Program loading only while stopped

    pipeline_core u_pipeline_core (.*);

    retire_tracker u_retire_tracker (.*);

    memory_arbiter u_memory_arbiter (.*);

    unified_memory u_unified_memory (
        .load_en (load_en_idle),
        .*
    );

endmodule

`default_nettype wire

/* verification/cpu_ref_model.svh */
// Reference interpreter over a memory copy that builds the expected retire stream
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Architectural state of the reference
word_t     ref_mem  [`CPU_MEM_DEPTH];  // Program and data image
word_t     ref_regs [`CPU_NUM_REGS];
int        ref_hold [`CPU_MEM_DEPTH];  // Expected decode holds, by pc

// Expected retire stream, oldest first
mem_addr_t exp_pc    [$];
logic      exp_we    [$];
reg_idx_t  exp_rd    [$];
word_t     exp_value [$];
seq_id_t   exp_id    [$];
hold_cnt_t exp_holds [$];

function automatic void clear_reference();
    for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
        ref_mem[i]  = '0;
        ref_hold[i] = 0;
    end
    for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        ref_regs[i] = '0;
    end
    exp_pc.delete();
    exp_we.delete();
    exp_rd.delete();
    exp_value.delete();
    exp_id.delete();
    exp_holds.delete();
endfunction

// Low six bits, sign extended
function automatic word_t imm_value(input word_t instr);
    return {{10{instr[5]}}, instr[5:0]};
endfunction

// Executes in program order from address 0 up to and including HALT
function automatic void run_reference();
    mem_addr_t pc;
    word_t     instr;
    opcode_e   op;
    reg_idx_t  rd;
    reg_idx_t  rs;
    word_t     a;
    word_t     b;
    word_t     res;
    mem_addr_t ea;
    logic      wr;
    logic      done;
    int        n;
    pc   = '0;
    done = 1'b0;
    n    = 0;
    while (!done && (n < `CPU_MEM_DEPTH)) begin
        instr = ref_mem[pc];
        op    = opcode_e'(instr[15:12]);
        rd    = instr[11:9];
        rs    = instr[8:6];
        a     = ref_regs[rd];                          // r0 entry is never written
        b     = ref_regs[rs];
        ea    = mem_addr_t'(b + imm_value(instr));     // Truncated to 8 bits
        res   = '0;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm_value(instr);
            OP_LD:   res = ref_mem[ea];
            OP_ST:   ref_mem[ea] = a;
            OP_HALT: done = 1'b1;
            default: res = '0;                         // NOP
        endcase
        wr = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD};
        if (wr && (rd != '0)) begin
            ref_regs[rd] = res;
        end
        exp_pc.push_back(pc);
        exp_we.push_back(wr);
        exp_rd.push_back(rd);
        exp_value.push_back(res);
        exp_id.push_back(seq_id_t'(n));                // One id per fetched instruction
        exp_holds.push_back(hold_cnt_t'(ref_hold[pc]));
        pc = pc + 8'd1;
        n++;
    end
endfunction

`endif

/* verification/cpu_tb.sv */
// Testbench for cpu_top with program loading, retire compare, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;
    import cpu_pkg::*;

    `include "cpu_ref_model.svh"

    localparam int unsigned SEED = 32'h9df9cf8c;
    localparam int LEN_ALU   = 10;  // Program lengths in words
    localparam int LEN_DEP   = 5;
    localparam int LEN_MEM   = 8;
    localparam int LEN_HALT  = 4;
    localparam int LEN_CLEAR = 4;
    localparam int WATCHDOG_CYCLES =
        (2 * LEN_ALU + LEN_DEP + LEN_MEM + LEN_HALT + LEN_CLEAR) * 20 + 200;
    localparam int WAIT_LIMIT = 200;  // Cycles one program may take

    logic      clk;
    logic      rst_n;
    logic      run;
    logic      load_en;
    mem_addr_t load_addr;
    word_t     load_data;
    logic      retire_valid;
    seq_id_t   retire_id;
    hold_cnt_t retire_holds;
    mem_addr_t retire_pc;
    logic      retire_we;
    reg_idx_t  retire_rd;
    word_t     retire_value;
    logic      halted;

    // Program image of the current test
    word_t     prog_words [$];
    int        prog_holds [$];   // Expected decode holds per instruction
    mem_addr_t data_addrs [$];
    word_t     data_words [$];

    int errors;
    int checks;
    int retire_count;
    int errors_before;

    cpu_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire_id    (retire_id),
        .retire_holds (retire_holds),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog sized from the program lengths
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected r%0d got r%0d", $time, name, exp, got);
        end
    endtask

    task automatic check_id(input string name, input seq_id_t got, input seq_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    // Every retire pulse against the next expected entry
    always @(posedge clk) begin
        if (rst_n && retire_valid) begin
            retire_count++;
            if (halted) begin
                report_problem("an instruction retired after halted rose");
            end else if (exp_pc.size() == 0) begin
                report_problem("an instruction retired with no expected entry left");
            end else begin
                check_word("retire_pc", word_t'(retire_pc), word_t'(exp_pc[0]));
                check_word("retire_we", word_t'(retire_we), word_t'(exp_we[0]));
                if (exp_we[0]) begin
                    check_reg("retire_rd", retire_rd, exp_rd[0]);
                    check_word("retire_value", retire_value, exp_value[0]);
                end
                check_id("retire_id", retire_id, exp_id[0]);
                check_word("retire_holds", word_t'(retire_holds), word_t'(exp_holds[0]));
                void'(exp_pc.pop_front());
                void'(exp_we.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_value.pop_front());
                void'(exp_id.pop_front());
                void'(exp_holds.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers, all entered on a falling edge
    ////////////////////////////////////////////////////////////

    function automatic word_t encode(input opcode_e op, input reg_idx_t rd,
                                     input reg_idx_t rs, input logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [5:0] random_imm();
        return 6'(($urandom % 63) + 1);  // Never zero, negative values included
    endfunction

    task automatic new_program();
        prog_words.delete();
        prog_holds.delete();
        data_addrs.delete();
        data_words.delete();
    endtask

    task automatic add_instr(input word_t instr, input int holds);
        prog_words.push_back(instr);
        prog_holds.push_back(holds);
    endtask

    task automatic add_data(input mem_addr_t addr, input word_t value);
        data_addrs.push_back(addr);
        data_words.push_back(value);
    endtask

    task automatic apply_reset();
        rst_n   = 1'b0;
        run     = 1'b0;
        load_en = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic load_word(input mem_addr_t addr, input word_t value);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = value;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // Load image, build the expected stream, then start fetch
    task automatic start_program();
        int i;
        clear_reference();
        retire_count = 0;
        for (i = 0; i < prog_words.size(); i++) begin
            load_word(mem_addr_t'(i), prog_words[i]);
            ref_mem[i]  = prog_words[i];
            ref_hold[i] = prog_holds[i];
        end
        for (i = 0; i < data_addrs.size(); i++) begin
            load_word(data_addrs[i], data_words[i]);
            ref_mem[data_addrs[i]] = data_words[i];
        end
        run_reference();
        run = 1'b1;
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!halted && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            report_problem("halted did not rise within the cycle limit");
        end
        repeat (10) @(negedge clk);  // A stray retirement would show here
        if (exp_pc.size() != 0) begin
            report_problem($sformatf("%0d expected retirements never came", exp_pc.size()));
        end
    endtask

    task automatic wait_for_retires(input int count);
        int cycles;
        cycles = 0;
        while ((retire_count < count) && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (retire_count < count) begin
            report_problem("too few retirements before the mid-run reset");
        end
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %s", num, name, (errors == errors_before) ? "ok" : "failed");
        errors_before = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Programs
    ////////////////////////////////////////////////////////////

    // No instruction reads a register written by either of the two before it
    task automatic build_alu_program();
        new_program();
        add_instr(encode(OP_ADDI, 3'd1, 3'd0, random_imm()), 0);
        add_instr(encode(OP_ADDI, 3'd2, 3'd0, random_imm()), 0);
        add_instr(encode(OP_ADDI, 3'd3, 3'd0, random_imm()), 0);
        add_instr(encode(OP_ADD,  3'd4, 3'd1, 6'd0), 0);
        add_instr(encode(OP_SUB,  3'd5, 3'd2, 6'd0), 0);
        add_instr(encode(OP_XOR,  3'd6, 3'd3, 6'd0), 0);
        add_instr(encode(OP_AND,  3'd4, 3'd2, 6'd0), 0);
        add_instr(encode(OP_ADDI, 3'd1, 3'd0, random_imm()), 0);
        add_instr(encode(OP_NOP,  3'd0, 3'd0, 6'd0), 0);
        add_instr(encode(OP_HALT, 3'd0, 3'd0, 6'd0), 0);
    endtask

    // Two consumers, each right behind its ALU producer
    task automatic build_dep_program();
        new_program();
        add_instr(encode(OP_ADDI, 3'd1, 3'd0, random_imm()), 0);
        add_instr(encode(OP_ADDI, 3'd2, 3'd0, random_imm()), 0);
        add_instr(encode(OP_ADD,  3'd2, 3'd1, 6'd0), 2);
        add_instr(encode(OP_XOR,  3'd3, 3'd2, 6'd0), 2);
        add_instr(encode(OP_HALT, 3'd0, 3'd0, 6'd0), 0);
    endtask

    // Data at F0..F3, reached as r0 plus a negative offset
    task automatic build_mem_program();
        new_program();
        add_instr(encode(OP_LD,   3'd1, 3'd0, 6'h30), 0);  // r1 = mem[F0]
        add_instr(encode(OP_LD,   3'd2, 3'd0, 6'h31), 0);
        add_instr(encode(OP_ADD,  3'd1, 3'd2, 6'd0), 2);   // Waits for the r2 load
        add_instr(encode(OP_ST,   3'd1, 3'd0, 6'h32), 2);  // mem[F2] = r1
        add_instr(encode(OP_LD,   3'd4, 3'd0, 6'h32), 0);  // Round trip of the store
        add_instr(encode(OP_LD,   3'd5, 3'd0, 6'h33), 0);
        add_instr(encode(OP_ADD,  3'd4, 3'd5, 6'd0), 0);   // Fetch bubbles cover the loads
        add_instr(encode(OP_HALT, 3'd0, 3'd0, 6'd0), 0);
        add_data(8'hf0, 16'h1234);
        add_data(8'hf1, 16'h0f0f);
        add_data(8'hf2, 16'hdead);  // Overwritten by the store
        add_data(8'hf3, 16'h7001);
    endtask

    task automatic build_halt_program();
        new_program();
        add_instr(encode(OP_ADDI, 3'd6, 3'd0, random_imm()), 0);
        add_instr(encode(OP_HALT, 3'd0, 3'd0, 6'd0), 0);
        add_instr(encode(OP_ADDI, 3'd7, 3'd0, 6'd1), 0);  // Never fetched
        add_instr(encode(OP_ADDI, 3'd7, 3'd0, 6'd1), 0);
    endtask

    // Reads of r1..r4, all zero right after reset
    task automatic build_clear_program();
        new_program();
        add_instr(encode(OP_ADD,  3'd1, 3'd2, 6'd0), 0);
        add_instr(encode(OP_XOR,  3'd3, 3'd4, 6'd0), 0);
        add_instr(encode(OP_ADDI, 3'd2, 3'd0, 6'd0), 0);
        add_instr(encode(OP_HALT, 3'd0, 3'd0, 6'd0), 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n         = 1'b0;
        run           = 1'b0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        errors        = 0;
        checks        = 0;
        retire_count  = 0;
        errors_before = 0;
        void'($urandom(SEED));
        @(negedge clk);

        apply_reset();
        build_alu_program();
        start_program();
        wait_for_halt();
        finish_test(1, "independent ALU sequence");

        apply_reset();
        build_dep_program();
        start_program();
        wait_for_halt();
        finish_test(2, "dependent pair");

        apply_reset();
        build_mem_program();
        start_program();
        wait_for_halt();
        finish_test(3, "loads and stores");

        apply_reset();
        build_halt_program();
        start_program();
        wait_for_halt();
        finish_test(4, "halt");

        // Stop part way through with registers already written
        apply_reset();
        build_alu_program();
        start_program();
        wait_for_retires(3);
        apply_reset();
        build_clear_program();
        start_program();
        wait_for_halt();
        finish_test(5, "reset mid-run");

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
+incdir+verification
common/cpu_pkg.sv
pipeline/register_file.sv
pipeline/pipeline_core.sv
hdl/memory_arbiter.sv
hdl/unified_memory.sv
hdl/retire_tracker.sv
hdl/cpu_top.sv
verification/cpu_tb.sv

/* build.sh */
#!/usr/bin/env bash
# Compile the CPU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module cpu_tb -f list.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0
